// ==== src/sb_settings.svh ====
// ------------------
// Store buffer settings
// Queue depth, bus widths and cache model size
// ------------------

`ifndef SB_SETTINGS_SVH
`define SB_SETTINGS_SVH

// Store queue
`define SB_NO_OF_LINES     8    // Entries in the circular queue
`define SB_PTR_WIDTH       3    // log2 of the queue depth

// Cache port
`define DCACHE_ADDR_WIDTH  32   // Byte address
`define DCACHE_DATA_WIDTH  32
`define DCACHE_SEL_WIDTH   4    // one select per byte lane

// Cache model
`define DCACHE_MEM_WORDS   64   // Words in the backing array

`endif

// ==== src/sb_pkg.sv ====
// ------------------
// Store buffer types
// Request, control and status structs shared by
// the LSU side, the queue and the cache port
// ------------------

`include "sb_settings.svh"

package sb_pkg;

    // Load or store request from the LSU
    typedef struct packed {
        logic [`DCACHE_ADDR_WIDTH-1:0] addr;
        logic [`DCACHE_DATA_WIDTH-1:0] wdata;     // Ignored on loads
        logic [`DCACHE_SEL_WIDTH-1:0]  sel_byte;
    } lsu_req_t;

    // One access on the cache port
    typedef struct packed {
        logic [`DCACHE_ADDR_WIDTH-1:0] addr;
        logic [`DCACHE_DATA_WIDTH-1:0] wdata;
        logic [`DCACHE_SEL_WIDTH-1:0]  sel_byte;
        logic                          we;        // 1 for drained stores
    } dcache_req_t;

    // Controller to datapath
    typedef struct packed {
        logic wr_en;          // Push LSU store at top_que
        logic bottom_que_en;  // Pop the drained entry
        logic clear_valid;
        logic kill_valid;     // Flush every entry
        logic read_sel;       // Capture forwarded data
    } sb_ctrl_t;

    // Datapath to controller
    typedef struct packed {
        logic tq_eq_bq;
        logic is_valid_bq;
        logic addr_not_available;  // No entry matches the LSU address
    } sb_status_t;

endpackage

// ==== src/store_buffer_datapath.sv ====
// ------------------
// Store buffer datapath
// Circular queue of pending stores with top and
// bottom pointers, load address match and
// newest-entry forwarding across wrap-around
// ------------------

`timescale 1ns/1ps
`include "sb_settings.svh"

module store_buffer_datapath (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sb_pkg::sb_ctrl_t              ctrl,
    input  sb_pkg::lsu_req_t              lsu_req,
    input  logic [`DCACHE_DATA_WIDTH-1:0] dcache_rdata,
    output sb_pkg::sb_status_t            status,
    output sb_pkg::dcache_req_t           drain_req,
    output logic [`DCACHE_DATA_WIDTH-1:0] fwd_data,
    output logic [`DCACHE_DATA_WIDTH-1:0] load_data_mux
);

    logic [`DCACHE_ADDR_WIDTH-1:0] addr_buffer    [`SB_NO_OF_LINES];
    logic [`DCACHE_DATA_WIDTH-1:0] data_buffer    [`SB_NO_OF_LINES];
    logic [`DCACHE_SEL_WIDTH-1:0]  selbyte_buffer [`SB_NO_OF_LINES];
    logic [`SB_NO_OF_LINES-1:0]    valid_buffer;     // Entry not yet written to the cache

    logic [`SB_PTR_WIDTH-1:0]      top_que;          // Next free slot
    logic [`SB_PTR_WIDTH-1:0]      bottom_que;       // Oldest entry, next to drain

    logic [`SB_NO_OF_LINES-1:0]    addr_availables;  // Per-entry match with the LSU request
    logic [`SB_NO_OF_LINES-1:0]    below_top_mask;
    logic [`SB_NO_OF_LINES-1:0]    below_top_hits;
    logic [`SB_PTR_WIDTH-1:0]      newest_index;
    logic                          fwd_sel_q;        // Response cycle of a load hit

    // Index of the highest set bit, zero when none
    function automatic logic [`SB_PTR_WIDTH-1:0] highest_set(
        input logic [`SB_NO_OF_LINES-1:0] vec
    );
        logic [`SB_PTR_WIDTH-1:0] idx;
        idx = '0;
        for (int i = 0; i < `SB_NO_OF_LINES; i++) begin
            if (vec[i]) begin
                idx = `SB_PTR_WIDTH'(i);
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_que    <= '0;
            bottom_que <= '0;
        end else begin
            if (ctrl.wr_en) begin
                top_que <= top_que + 1'b1;
            end
            if (ctrl.kill_valid) begin
                bottom_que <= top_que;               // Flush leaves an empty queue
            end else if (ctrl.bottom_que_en) begin
                bottom_que <= bottom_que + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_buffer <= '0;
        end else if (ctrl.kill_valid) begin
            valid_buffer <= '0;
        end else begin
            if (ctrl.clear_valid) begin
                valid_buffer[bottom_que] <= 1'b0;    // Drained this cycle
            end
            if (ctrl.wr_en) begin
                valid_buffer[top_que] <= 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (ctrl.wr_en) begin
            addr_buffer[top_que]    <= lsu_req.addr;
            data_buffer[top_que]    <= lsu_req.wdata;
            selbyte_buffer[top_que] <= lsu_req.sel_byte;
        end
    end

    // Exact match only, partial overlaps go to the cache
    always_comb begin
        for (int j = 0; j < `SB_NO_OF_LINES; j++) begin
            addr_availables[j] = valid_buffer[j]
                              && (addr_buffer[j] == lsu_req.addr)
                              && (selbyte_buffer[j] == lsu_req.sel_byte);
        end
    end

    // Entries below top_que are the newest; above it only when wrapped
    assign below_top_mask = (`SB_NO_OF_LINES'(1) << top_que) - 1'b1;
    assign below_top_hits = addr_availables & below_top_mask;
    assign newest_index   = (|below_top_hits) ? highest_set(below_top_hits)
                                              : highest_set(addr_availables);

    always_ff @(posedge clk) begin
        if (ctrl.read_sel) begin
            fwd_data <= data_buffer[newest_index];  // Held for the ack cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_sel_q <= 1'b0;
        end else begin
            fwd_sel_q <= ctrl.read_sel;
        end
    end

    assign load_data_mux = fwd_sel_q ? fwd_data : dcache_rdata;

    always_comb begin
        status.tq_eq_bq           = (top_que == bottom_que);
        status.is_valid_bq        = valid_buffer[bottom_que];
        status.addr_not_available = (addr_availables == '0);
        drain_req.addr            = addr_buffer[bottom_que];   // Oldest entry goes first
        drain_req.wdata           = data_buffer[bottom_que];
        drain_req.sel_byte        = selbyte_buffer[bottom_que];
        drain_req.we              = 1'b1;
    end

    // Controller must hold off stores while full
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.wr_en |-> !valid_buffer[top_que]);

    // A drain grant only pops a live entry
    a_clear_only_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.clear_valid |-> valid_buffer[bottom_que]);

endmodule

// ==== src/store_buffer_controller.sv ====
// ------------------
// Store buffer controller
// Accepts stores, drives the drain request and
// runs the load FSM for hits and cache misses
// ------------------

`timescale 1ns/1ps

module store_buffer_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               store_req,
    input  logic               load_req,
    input  logic               kill,
    input  sb_pkg::sb_status_t status,
    input  logic               load_grant,
    input  logic               drain_grant,
    input  logic               mem_rvalid,
    output sb_pkg::sb_ctrl_t   ctrl,
    output logic               store_ack,
    output logic               load_ack,
    output logic               load_busy,
    output logic               load_miss_req,
    output logic               drain_valid,
    output logic               sb_full,
    output logic               sb_empty
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD_HIT,    // Forwarded data goes out
        LOAD_WAIT,   // Miss waits for the cache port
        LOAD_RESP    // Cache read in flight
    } state_t;

    state_t state;
    state_t next_state;
    logic   load_hit;

    // Pointers equal means either all free or all used
    assign sb_full  = status.tq_eq_bq &&  status.is_valid_bq;
    assign sb_empty = status.tq_eq_bq && !status.is_valid_bq;

    assign store_ack   = store_req && !sb_full && !kill;   // No push during a flush
    assign drain_valid = status.is_valid_bq && !kill;
    assign load_hit    = load_req && !status.addr_not_available;
    assign load_busy   = (state != IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state         = state;
        load_ack           = 1'b0;
        load_miss_req      = 1'b0;
        ctrl.wr_en         = store_ack;
        ctrl.bottom_que_en = drain_grant;     // Pop with the cache write
        ctrl.clear_valid   = drain_grant;
        ctrl.kill_valid    = kill;
        ctrl.read_sel      = 1'b0;
        case (state)
            IDLE: begin
                if (load_req) begin
                    ctrl.read_sel = load_hit;  // Latch forwarded data now
                    next_state    = load_hit ? LOAD_HIT : LOAD_WAIT;
                end
            end
            LOAD_HIT: begin
                load_ack   = 1'b1;
                next_state = IDLE;
            end
            LOAD_WAIT: begin
                load_miss_req = 1'b1;          // Held until granted
                if (load_grant) begin
                    next_state = LOAD_RESP;
                end
            end
            LOAD_RESP: begin
                if (mem_rvalid) begin
                    load_ack   = 1'b1;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // One outstanding load at a time
    a_single_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_req |-> !load_busy);

endmodule

// ==== src/dcache_arbiter.sv ====
// ------------------
// Cache port arbiter
// Fixed priority, load misses ahead of the
// store drain, one grant per cycle
// ------------------

`timescale 1ns/1ps

module dcache_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_miss_req,
    input  sb_pkg::lsu_req_t    load_addr,
    input  logic                drain_valid,
    input  sb_pkg::dcache_req_t drain_req,
    output logic                load_grant,
    output logic                drain_grant,
    output sb_pkg::dcache_req_t mem_req,
    output logic                mem_en
);

    sb_pkg::lsu_req_t load_hold;   // LSU request from the load cycle

    // Tracks the LSU until the miss is raised, then holds
    always_ff @(posedge clk) begin
        if (!load_miss_req) begin
            load_hold <= load_addr;
        end
    end

    assign load_grant  = load_miss_req;
    assign drain_grant = drain_valid && !load_miss_req;   // Drain yields to loads
    assign mem_en      = load_grant || drain_grant;

    always_comb begin
        if (load_grant) begin
            mem_req.addr     = load_hold.addr;
            mem_req.wdata    = '0;
            mem_req.sel_byte = load_hold.sel_byte;
            mem_req.we       = 1'b0;
        end else begin
            mem_req = drain_req;        // Qualified by mem_en
        end
    end

    // A drain held off by a load miss gets the port in the next cycle
    a_drain_not_starved: assert property (@(posedge clk) disable iff (!rst_n)
        drain_valid && load_miss_req |=> drain_grant || !drain_valid);

endmodule

// ==== src/dcache_mem.sv ====
// ------------------
// Data cache model
// Word array, byte-enabled writes and a
// registered read one cycle after the request
// ------------------

`timescale 1ns/1ps
`include "sb_settings.svh"

module dcache_mem (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_en,
    input  sb_pkg::dcache_req_t           mem_req,
    output logic [`DCACHE_DATA_WIDTH-1:0] mem_rdata,
    output logic                          mem_rvalid
);

    localparam int WORD_AW  = $clog2(`DCACHE_MEM_WORDS);
    localparam int BYTE_OFS = $clog2(`DCACHE_DATA_WIDTH / 8);   // Byte offset bits

    // Starts all zero
    logic [`DCACHE_DATA_WIDTH-1:0] mem_array [`DCACHE_MEM_WORDS] = '{default: '0};
    logic [WORD_AW-1:0]            word_idx;

    assign word_idx = mem_req.addr[BYTE_OFS +: WORD_AW];   // Upper bits alias

    // Merge only the selected byte lanes
    always_ff @(posedge clk) begin
        if (mem_en && mem_req.we) begin
            for (int b = 0; b < `DCACHE_SEL_WIDTH; b++) begin
                if (mem_req.sel_byte[b]) begin
                    mem_array[word_idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_en && !mem_req.we) begin
            mem_rdata <= mem_array[word_idx];   // Whole word, LSU picks the bytes
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rvalid <= 1'b0;
        end else begin
            mem_rvalid <= mem_en && !mem_req.we;   // Reads only
        end
    end

endmodule

// ==== src/sb_subsystem_top.sv ====
// ------------------
// Store buffer subsystem
// Controller, queue datapath, cache port
// arbiter and cache model
// ------------------

`timescale 1ns/1ps
`include "sb_settings.svh"

module sb_subsystem_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sb_pkg::lsu_req_t              lsu_req,
    input  logic                          store_req,
    input  logic                          load_req,
    input  logic                          kill,
    output logic                          store_ack,
    output logic                          load_ack,
    output logic [`DCACHE_DATA_WIDTH-1:0] load_data,
    output logic                          load_busy,
    output logic                          sb_full,
    output logic                          sb_empty
);

    sb_pkg::sb_ctrl_t              ctrl;
    sb_pkg::sb_status_t            status;
    sb_pkg::dcache_req_t           drain_req;   // Bottom entry
    sb_pkg::dcache_req_t           mem_req;     // Granted access
    logic                          load_miss_req;
    logic                          drain_valid;
    logic                          load_grant;
    logic                          drain_grant;
    logic                          mem_en;
    logic                          mem_rvalid;
    logic [`DCACHE_DATA_WIDTH-1:0] mem_rdata;

    store_buffer_controller u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .store_req     (store_req),
        .load_req      (load_req),
        .kill          (kill),
        .status        (status),
        .load_grant    (load_grant),
        .drain_grant   (drain_grant),
        .mem_rvalid    (mem_rvalid),
        .ctrl          (ctrl),
        .store_ack     (store_ack),
        .load_ack      (load_ack),
        .load_busy     (load_busy),
        .load_miss_req (load_miss_req),
        .drain_valid   (drain_valid),
        .sb_full       (sb_full),
        .sb_empty      (sb_empty)
    );

    store_buffer_datapath u_dp (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .lsu_req       (lsu_req),
        .dcache_rdata  (mem_rdata),
        .status        (status),
        .drain_req     (drain_req),
        .fwd_data      (),            // Already folded into load_data_mux
        .load_data_mux (load_data)
    );

    dcache_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_miss_req (load_miss_req),
        .load_addr     (lsu_req),
        .drain_valid   (drain_valid),
        .drain_req     (drain_req),
        .load_grant    (load_grant),
        .drain_grant   (drain_grant),
        .mem_req       (mem_req),
        .mem_en        (mem_en)
    );

    dcache_mem u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_en        (mem_en),
        .mem_req       (mem_req),
        .mem_rdata     (mem_rdata),
        .mem_rvalid    (mem_rvalid)
    );

endmodule

// ==== testbench/sb_tb.sv ====
// --------------------
// Store buffer testbench
// Directed tests of forwarding, drain, byte merge,
// wrap-around and flush, checked against a
// reference model of memory and pending stores
// --------------------

`timescale 1ns/1ps
`include "sb_settings.svh"

module sb_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    localparam int SEED       = 40317;

    logic                          clk;
    logic                          rst_n;
    sb_pkg::lsu_req_t              lsu_req;
    logic                          store_req;
    logic                          load_req;
    logic                          kill;
    logic                          store_ack;
    logic                          load_ack;
    logic [`DCACHE_DATA_WIDTH-1:0] load_data;
    logic                          load_busy;
    logic                          sb_full;
    logic                          sb_empty;

    logic [`DCACHE_DATA_WIDTH-1:0] ref_mem [`DCACHE_MEM_WORDS];  // Drained stores only
    sb_pkg::lsu_req_t              pending [$];                 // Accepted, oldest first

    int   checks;
    int   errors;
    int   test_errors;
    int   load_latency;          // Cycles from load_req to load_ack
    logic empty_in_load_cycle;   // sb_empty seen in the load_req cycle

    sb_subsystem_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .lsu_req   (lsu_req),
        .store_req (store_req),
        .load_req  (load_req),
        .kill      (kill),
        .store_ack (store_ack),
        .load_ack  (load_ack),
        .load_data (load_data),
        .load_busy (load_busy),
        .sb_full   (sb_full),
        .sb_empty  (sb_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 400 cycles per test is far above the longest test
    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Watchdog expired, the DUT stopped answering");
        $display("Checks failed");
        $finish;
    end

    // Byte lanes picked by a select
    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        logic [31:0] m;
        m = '0;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                m[b*8 +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    function automatic int word_of(input logic [31:0] addr);
        return (addr >> 2) % `DCACHE_MEM_WORDS;   // Cache model wraps its index
    endfunction

    // Every pending store has reached the cache, merge in order
    function automatic void retire_pending();
        sb_pkg::lsu_req_t e;
        while (pending.size() > 0) begin
            e = pending.pop_front();
            ref_mem[word_of(e.addr)] = (ref_mem[word_of(e.addr)] & ~lane_mask(e.sel_byte))
                                     | (e.wdata & lane_mask(e.sel_byte));
        end
    endfunction

    // Newest exact match wins, otherwise the cache word
    function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [3:0] sel);
        for (int i = pending.size() - 1; i >= 0; i--) begin
            if (pending[i].addr == addr && pending[i].sel_byte == sel) begin
                return pending[i].wdata;
            end
        end
        return ref_mem[word_of(addr)];
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        store_req <= 1'b0;
        load_req  <= 1'b0;
        kill      <= 1'b0;
    endtask

    // Holds the strobe until store_ack, then records the store
    task automatic push_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] sel);
        sb_pkg::lsu_req_t req;
        req.addr     = addr;
        req.wdata    = data;
        req.sel_byte = sel;
        @(posedge clk);
        lsu_req   <= req;
        store_req <= 1'b1;
        load_req  <= 1'b0;
        kill      <= 1'b0;
        @(negedge clk);
        if (!sb_full) begin
            expect_equal("store_ack", store_ack, 1);   // Same-cycle ack while there is room
        end
        while (!store_ack) begin
            @(negedge clk);            // Stalled by sb_full
        end
        pending.push_back(req);
    endtask

    // One load, compared on the selected lanes only
    task automatic issue_load(input logic [31:0] addr, input logic [3:0] sel);
        sb_pkg::lsu_req_t req;
        logic [31:0]      exp;
        req.addr     = addr;
        req.wdata    = '0;
        req.sel_byte = sel;
        exp          = model_load(addr, sel);
        @(posedge clk);
        lsu_req   <= req;
        store_req <= 1'b0;
        load_req  <= 1'b1;
        kill      <= 1'b0;
        @(negedge clk);
        empty_in_load_cycle = sb_empty;
        @(posedge clk);
        load_req <= 1'b0;
        load_latency = 1;
        @(negedge clk);
        while (!load_ack) begin
            @(negedge clk);
            load_latency++;
        end
        expect_equal("load_data", load_data & lane_mask(sel), exp & lane_mask(sel));
    endtask

    task automatic wait_drained();
        idle_cycle();
        @(negedge clk);
        while (!sb_empty) begin
            @(negedge clk);
        end
        retire_pending();
    endtask

    // Queue starts empty and drains one entry per cycle, so only the
    // last store of the burst is still pending when kill arrives
    task automatic flush_after_burst(input int n);
        wait_drained();
        for (int i = 0; i < n; i++) begin
            push_store(32'h40 + 4 * $urandom_range(0, 3), $urandom, 4'hf);
        end
        @(posedge clk);
        store_req <= 1'b0;
        kill      <= 1'b1;
        @(posedge clk);
        kill <= 1'b0;
        @(negedge clk);
        expect_equal("sb_empty", sb_empty, 1);
        void'(pending.pop_back());     // Killed before it drained
        retire_pending();
    endtask

    task automatic report_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("Test %0d %-24s ok", num, name);
        end else begin
            $display("Test %0d %-24s %0d error(s)", num, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        expect_equal("sb_empty", sb_empty, 1);
        expect_equal("sb_full", sb_full, 0);
        expect_equal("load_busy", load_busy, 0);
        expect_equal("store_ack", store_ack, 0);
        expect_equal("load_ack", load_ack, 0);
        issue_load(32'h10, 4'hf);       // Cache starts at zero
        expect_equal("load_ack latency", load_latency, 2);
    endtask

    task automatic forward_after_store();
        push_store(32'h14, 32'hcafe_0123, 4'h3);
        issue_load(32'h14, 4'h3);
        expect_equal("sb_empty", empty_in_load_cycle, 0);
        expect_equal("load_ack latency", load_latency, 1);
        wait_drained();
    endtask

    task automatic forward_newest();
        push_store(32'h18, 32'h1111_1111, 4'hf);
        push_store(32'h18, 32'h2222_2222, 4'hf);
        push_store(32'h18, 32'h3333_3333, 4'hf);
        issue_load(32'h18, 4'hf);
        expect_equal("load_ack latency", load_latency, 1);
        wait_drained();
        issue_load(32'h18, 4'hf);       // Now from the cache
    endtask

    // Single-byte stores to two words, merged in the cache
    task automatic fill_and_merge();
        for (int i = 0; i < 8; i++) begin
            push_store(32'h20 + 4 * (i / 4), $urandom, 4'(1 << (i % 4)));
        end
        idle_cycle();                   // Last store is written at this edge
        @(posedge clk);                 // and drained at this one
        @(negedge clk);
        expect_equal("sb_empty", sb_empty, 1);
        retire_pending();
        issue_load(32'h20, 4'hf);
        issue_load(32'h24, 4'hf);
    endtask

    // Top sits at 4 here, so the same-address stores land at 7, 0, 1
    task automatic wrap_forward();
        for (int i = 0; i < 3; i++) begin
            push_store(32'h30 + 4 * i, $urandom, 4'hf);
        end
        push_store(32'h2c, 32'haaaa_0007, 4'hf);
        push_store(32'h2c, 32'hbbbb_0000, 4'hf);
        push_store(32'h2c, 32'hcccc_0001, 4'hf);
        issue_load(32'h2c, 4'hf);
        expect_equal("load_ack latency", load_latency, 1);
        wait_drained();
    endtask

    task automatic random_mix_with_kill();
        logic [31:0] addr;
        for (int i = 0; i < 40; i++) begin
            if (i == 20) begin
                flush_after_burst(3);
                for (int a = 0; a < 4; a++) begin
                    issue_load(32'h40 + 4 * a, 4'hf);
                end
            end
            addr = 32'h40 + 4 * $urandom_range(0, 3);
            case ($urandom_range(0, 2))
                0: push_store(addr, $urandom, 4'hf);
                1: issue_load(addr, 4'hf);
                default: idle_cycle();
            endcase
        end
        wait_drained();
    endtask

    initial begin
        void'($urandom(SEED));
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0;
        end
        rst_n     = 1'b0;
        lsu_req   = '0;
        store_req = 1'b0;
        load_req  = 1'b0;
        kill      = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        check_reset_state();
        report_test(1, "reset state");
        forward_after_store();
        report_test(2, "store then load");
        forward_newest();
        report_test(3, "newest of three");
        fill_and_merge();
        report_test(4, "eight stores and merge");
        wrap_forward();
        report_test(5, "wrap-around forward");
        random_mix_with_kill();
        report_test(6, "random mix with kill");

        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+src
src/sb_pkg.sv
src/store_buffer_datapath.sv
src/store_buffer_controller.sv
src/dcache_arbiter.sv
src/dcache_mem.sv
src/sb_subsystem_top.sv
testbench/sb_tb.sv

// ==== Makefile ====
# Verilator build and run of the store buffer testbench

TOP := sb_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "Simulation FAILED" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
